// File: include/tlu_defs.svh
// word widths, TLU clock divisor, glitch guard, sync margin and maximum bit count
`ifndef TLU_DEFS_SVH
`define TLU_DEFS_SVH

// trigger word, timestamp and trigger counter
`define TLU_WORD_W 32

// payload below the marker bit
`define TLU_PAYLOAD_W 31

// TRIGGER_CLK cycles per TLU clock bit
`define TLU_DIVISOR 4

// minimum cycles in the trigger-low wait, masks TLU glitches
`define TLU_GUARD_CYCLES 5

// extra cycles after the data delay before latching
`define TLU_SYNC_MARGIN 3

// bit count selected by a setting of 0
`define TLU_MAX_BITS 32

`endif

// File: logic/tlu_controller.sv
// TLU controller top level, FSM, cycle timer, deserializer and trigger record
`timescale 1ns/1ps
`include "tlu_defs.svh"

module tlu_controller #(
    parameter int divisor = `TLU_DIVISOR
) (
    input  logic                   TRIGGER_CLK,
    input  logic                   RESET,
    input  logic                   trigger,
    input  logic                   trigger_flag,
    input  logic                   trigger_veto,
    input  logic                   trigger_enable,
    input  logic                   trigger_acknowledge,
    input  tlu_pkg::tlu_mode_t     tlu_mode,
    input  logic [7:0]             tlu_trigger_low_time_out,
    input  logic [4:0]             tlu_clock_cycles,
    input  logic [3:0]             tlu_trigger_data_delay,
    input  logic                   tlu_trigger_data_msb_first,
    input  logic                   tlu_enable_veto,
    input  logic                   tlu_reset_flag,
    input  logic                   write_timestamp,
    input  logic                   trigger_counter_set,
    input  logic [`TLU_WORD_W-1:0] trigger_counter_set_value,
    output logic                   trigger_data_write,
    output logic [`TLU_WORD_W-1:0] trigger_data,
    output logic                   fifo_preempt_req,
    output logic                   trigger_accepted_flag,
    output logic [`TLU_WORD_W-1:0] timestamp_data,
    output logic [`TLU_WORD_W-1:0] trigger_counter_data,
    output logic                   busy,
    output logic                   tlu_clock_enable,
    output logic                   tlu_assert_veto,
    output logic                   low_timeout_error,
    output logic                   accept_error
);
    logic                      capture;
    logic                      latch;
    logic [`TLU_PAYLOAD_W-1:0] tlu_number;

    tlu_timer_if timer_if ();

    tlu_handshake_fsm fsm_i (
        .TRIGGER_CLK, .RESET, .trigger, .trigger_flag, .trigger_veto, .trigger_enable,
        .trigger_acknowledge, .tlu_enable_veto, .tlu_mode, .tlu_clock_cycles,
        .timer (timer_if.fsm),
        .busy, .tlu_clock_enable, .tlu_assert_veto, .trigger_accepted_flag,
        .fifo_preempt_req, .trigger_data_write, .capture, .latch, .accept_error,
        .low_timeout_error
    );

    tlu_cycle_timer #(.divisor(divisor)) timer_i (
        .TRIGGER_CLK, .RESET, .tlu_trigger_low_time_out, .tlu_trigger_data_delay,
        .timer (timer_if.timer)
    );

    tlu_data_deserializer #(.divisor(divisor)) deser_i (
        .TRIGGER_CLK, .RESET, .trigger, .tlu_clock_enable, .latch,
        .tlu_trigger_data_delay, .tlu_trigger_data_msb_first, .tlu_clock_cycles,
        .tlu_number
    );

    trigger_record record_i (
        .TRIGGER_CLK, .RESET, .tlu_reset_flag, .trigger_counter_set,
        .trigger_counter_set_value, .trigger_accepted_flag, .capture, .write_timestamp,
        .tlu_mode, .tlu_number, .trigger_data, .trigger_counter_data, .timestamp_data
    );

endmodule

// File: logic/tlu_cycle_timer.sv
// phase counters for glitch guard, low time-out, TLU clock bits and wait-before-latch
`timescale 1ns/1ps
`include "tlu_defs.svh"

module tlu_cycle_timer #(
    parameter int divisor = `TLU_DIVISOR
) (
    input  logic       TRIGGER_CLK,
    input  logic       RESET,
    input  logic [7:0] tlu_trigger_low_time_out,
    input  logic [3:0] tlu_trigger_data_delay,
    tlu_timer_if.timer timer
);
    import tlu_pkg::*;

    localparam int clk_w = $clog2(`TLU_MAX_BITS * divisor + 1);

    logic [7:0]       low_cnt;
    logic [clk_w-1:0] clk_cnt;
    logic [clk_w-1:0] clock_total;
    logic [4:0]       wait_cnt;
    logic [4:0]       wait_total;

    assign clock_total = clk_w'(timer.bit_count) * clk_w'(divisor);
    assign wait_total  = 5'(tlu_trigger_data_delay) + 5'(`TLU_SYNC_MARGIN);

    // done flags are one cycle late, so compare against total minus two
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            low_cnt           <= '0;
            clk_cnt           <= '0;
            wait_cnt          <= '0;
            timer.guard_done  <= 1'b0;
            timer.low_timeout <= 1'b0;
            timer.clock_done  <= 1'b0;
            timer.wait_done   <= 1'b0;
        end
        else
        begin
            if (timer.phase != WAIT_TRIGGER_LOW)
                low_cnt <= '0;
            else if (low_cnt != 8'hff)
                low_cnt <= low_cnt + 8'd1; // saturates when time-out is off
            clk_cnt  <= (timer.phase == SEND_TLU_CLOCK) ? clk_cnt + clk_w'(1) : '0;
            wait_cnt <= (timer.phase == WAIT_BEFORE_LATCH) ? wait_cnt + 5'd1 : '0;

            timer.guard_done <= (timer.phase == WAIT_TRIGGER_LOW)
                                && (low_cnt >= 8'(`TLU_GUARD_CYCLES - 1));
            timer.clock_done <= (timer.phase == SEND_TLU_CLOCK)
                                && (clk_cnt == clock_total - clk_w'(2));
            timer.wait_done  <= (timer.phase == WAIT_BEFORE_LATCH)
                                && (wait_cnt == wait_total - 5'd2);

            if (timer.phase == IDLE)
                timer.low_timeout <= 1'b0;
            else if (timer.phase == WAIT_TRIGGER_LOW && tlu_trigger_low_time_out != 8'd0
                     && low_cnt >= tlu_trigger_low_time_out)
                timer.low_timeout <= 1'b1;
        end
    end

    a_clock_bound: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        clk_cnt <= clk_w'(`TLU_MAX_BITS * divisor));

endmodule

// File: logic/tlu_data_deserializer.sv
// delayed sampling and bit assembly of the serial TLU trigger number
`timescale 1ns/1ps
`include "tlu_defs.svh"

module tlu_data_deserializer #(
    parameter int divisor = `TLU_DIVISOR
) (
    input  logic                      TRIGGER_CLK,
    input  logic                      RESET,
    input  logic                      trigger,
    input  logic                      tlu_clock_enable,
    input  logic                      latch,
    input  logic [3:0]                tlu_trigger_data_delay,
    input  logic                      tlu_trigger_data_msb_first,
    input  logic [4:0]                tlu_clock_cycles,
    output logic [`TLU_PAYLOAD_W-1:0] tlu_number
);
    localparam int dw = (divisor > 1) ? $clog2(divisor) : 1;

    logic [15:0]                en_line;   // enable history, tap 0 is one cycle old
    logic                       trig_q;
    logic                       en_del;
    logic [dw-1:0]              div_cnt;
    logic [`TLU_MAX_BITS-1:0]   sample_sr; // newest bit at 0
    logic [5:0]                 n_bits;
    logic [`TLU_PAYLOAD_W-1:0]  packed_bits;

    assign n_bits = (tlu_clock_cycles == 5'd0) ? 6'(`TLU_MAX_BITS) : {1'b0, tlu_clock_cycles};

    // the TLU answers late, so the sample window follows the data
    assign en_del = en_line[tlu_trigger_data_delay];

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            en_line <= '0;
            div_cnt <= '0;
        end
        else
        begin
            en_line <= {en_line[14:0], tlu_clock_enable};
            if (!en_del || div_cnt == dw'(divisor - 1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + dw'(1);
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        trig_q <= trigger;
        if (en_del && div_cnt == dw'(divisor - 1))
            sample_sr <= {sample_sr[`TLU_MAX_BITS-2:0], trig_q}; // end of bit period
        if (latch)
            tlu_number <= packed_bits;
    end

    // start bit sits at n_bits-1 and is dropped
    always_comb
    begin
        packed_bits = '0;
        for (int i = 0; i < `TLU_PAYLOAD_W; i++)
        begin
            if (i < int'(n_bits) - 1)
            begin
                if (tlu_trigger_data_msb_first)
                    packed_bits[i] = sample_sr[i];
                else
                    packed_bits[i] = sample_sr[int'(n_bits) - 2 - i];
            end
        end
    end

endmodule

// File: logic/tlu_handshake_fsm.sv
// trigger acceptance and TLU handshake FSM with registered control outputs
`timescale 1ns/1ps
`include "tlu_defs.svh"

module tlu_handshake_fsm (
    input  logic                TRIGGER_CLK,
    input  logic                RESET,
    input  logic                trigger,
    input  logic                trigger_flag,
    input  logic                trigger_veto,
    input  logic                trigger_enable,
    input  logic                trigger_acknowledge,
    input  logic                tlu_enable_veto,
    input  tlu_pkg::tlu_mode_t  tlu_mode,
    input  logic [4:0]          tlu_clock_cycles,
    tlu_timer_if.fsm            timer,
    output logic                busy,
    output logic                tlu_clock_enable,
    output logic                tlu_assert_veto,
    output logic                trigger_accepted_flag,
    output logic                fifo_preempt_req,
    output logic                trigger_data_write,
    output logic                capture,
    output logic                latch,
    output logic                accept_error,
    output logic                low_timeout_error
);
    import tlu_pkg::*;

    tlu_state_t state;
    tlu_state_t next;
    logic       hs_mode;     // busy handshake with the TLU
    logic       flag_mode;
    logic       accept;
    logic       acked;       // acknowledge seen during this sequence
    logic       start_pulse;

    assign hs_mode   = (tlu_mode == MODE_HANDSHAKE) || (tlu_mode == MODE_DATA);
    assign flag_mode = (tlu_mode == MODE_FLAG) || (tlu_mode == MODE_FLAG_ALT);

    // veto only blocks flag triggers, the TLU is held off by tlu_assert_veto
    assign accept = !trigger_acknowledge && trigger_enable
                    && (trigger_flag || (trigger && hs_mode))
                    && (!trigger_veto || hs_mode);

    assign timer.phase     = state;
    assign timer.bit_count = (tlu_clock_cycles == 5'd0) ? 6'(`TLU_MAX_BITS)
                                                        : {1'b0, tlu_clock_cycles};

    assign trigger_accepted_flag = start_pulse;
    assign fifo_preempt_req      = start_pulse;
    assign capture               = start_pulse;
    assign low_timeout_error     = timer.low_timeout;

    // last wait cycle, number is registered as LATCH_DATA begins
    assign latch = (state == WAIT_BEFORE_LATCH) && timer.wait_done;

    always_comb
    begin
        next = state;
        case (state)
            IDLE:              if (accept) next = WAIT_TRIGGER_LOW;
            WAIT_TRIGGER_LOW:
            begin
                if (flag_mode)
                    next = LATCH_DATA; // no TLU line to wait on
                else if (timer.guard_done && (!trigger || timer.low_timeout))
                    next = (tlu_mode == MODE_DATA) ? SEND_TLU_CLOCK : LATCH_DATA;
            end
            SEND_TLU_CLOCK:    if (timer.clock_done) next = WAIT_BEFORE_LATCH;
            WAIT_BEFORE_LATCH: if (timer.wait_done) next = LATCH_DATA;
            LATCH_DATA:        next = WAIT_ACK;
            WAIT_ACK:          if (trigger_acknowledge || acked) next = IDLE;
            default:           next = IDLE;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            state              <= IDLE;
            busy               <= 1'b0;
            tlu_clock_enable   <= 1'b0;
            tlu_assert_veto    <= 1'b0;
            start_pulse        <= 1'b0;
            trigger_data_write <= 1'b0;
            accept_error       <= 1'b0;
            acked              <= 1'b0;
        end
        else
        begin
            state              <= next;
            start_pulse        <= (state == IDLE) && (next == WAIT_TRIGGER_LOW);
            tlu_clock_enable   <= (next == SEND_TLU_CLOCK);
            trigger_data_write <= (next == LATCH_DATA);
            tlu_assert_veto    <= (next == IDLE) && (!trigger_enable
                                  || (tlu_enable_veto && trigger_veto && hs_mode));
            case (next)
                IDLE:
                begin
                    busy         <= 1'b0;
                    acked        <= 1'b0;
                    accept_error <= trigger && trigger_enable; // TLU line high but not taken
                end
                WAIT_ACK:
                begin
                    if (trigger_acknowledge || acked)
                        busy <= 1'b0; // release the TLU as early as possible
                    acked <= acked | trigger_acknowledge;
                end
                default:
                begin
                    busy  <= 1'b1;
                    acked <= acked | trigger_acknowledge;
                end
            endcase
        end
    end

    // busy holds from acceptance until an acknowledge has been seen
    a_busy_until_ack: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        (state != IDLE && !acked) |-> busy);

    a_single_write: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |=> !trigger_data_write);

endmodule

// File: logic/tlu_pkg.sv
// TLU controller state and trigger mode types
package tlu_pkg;

    // controller sequence
    typedef enum logic [2:0] {
        IDLE              = 3'd0,
        WAIT_TRIGGER_LOW  = 3'd1,
        SEND_TLU_CLOCK    = 3'd2,
        WAIT_BEFORE_LATCH = 3'd3,
        LATCH_DATA        = 3'd4,
        WAIT_ACK          = 3'd5
    } tlu_state_t;

    // trigger source and TLU protocol
    typedef enum logic [1:0] {
        MODE_FLAG      = 2'b00,
        MODE_FLAG_ALT  = 2'b01, // same as flag mode
        MODE_HANDSHAKE = 2'b10,
        MODE_DATA      = 2'b11
    } tlu_mode_t;

endpackage

// File: logic/tlu_timer_if.sv
// interface between handshake FSM and cycle timer, fsm and timer modports
`timescale 1ns/1ps

interface tlu_timer_if;
    import tlu_pkg::*;

    tlu_state_t phase;     // registered state of the FSM
    logic [5:0] bit_count; // 1..32, zero already mapped
    logic       guard_done;
    logic       low_timeout; // sticky until IDLE
    logic       clock_done;
    logic       wait_done;

    modport fsm (
        output phase, bit_count,
        input  guard_done, low_timeout, clock_done, wait_done
    );

    modport timer (
        input  phase, bit_count,
        output guard_done, low_timeout, clock_done, wait_done
    );

endinterface

// File: logic/trigger_record.sv
// timestamp, trigger counter, snapshots and trigger word selection
`timescale 1ns/1ps
`include "tlu_defs.svh"

module trigger_record (
    input  logic                      TRIGGER_CLK,
    input  logic                      RESET,
    input  logic                      tlu_reset_flag,
    input  logic                      trigger_counter_set,
    input  logic [`TLU_WORD_W-1:0]    trigger_counter_set_value,
    input  logic                      trigger_accepted_flag,
    input  logic                      capture,
    input  logic                      write_timestamp,
    input  tlu_pkg::tlu_mode_t        tlu_mode,
    input  logic [`TLU_PAYLOAD_W-1:0] tlu_number,
    output logic [`TLU_WORD_W-1:0]    trigger_data,
    output logic [`TLU_WORD_W-1:0]    trigger_counter_data,
    output logic [`TLU_WORD_W-1:0]    timestamp_data
);
    import tlu_pkg::*;

    logic [`TLU_WORD_W-1:0]    timestamp;
    logic [`TLU_WORD_W-1:0]    trigger_counter;
    logic [`TLU_PAYLOAD_W-1:0] payload;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || tlu_reset_flag)
            timestamp <= '0; // TLU reset aligns timestamps across the setup
        else
            timestamp <= timestamp + `TLU_WORD_W'(1);
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_counter <= '0;
        else if (trigger_counter_set)
            trigger_counter <= trigger_counter_set_value;
        else if (trigger_accepted_flag)
            trigger_counter <= trigger_counter + `TLU_WORD_W'(1);
    end

    // capture comes with the accepted flag, so the count is the pre-increment one
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (capture)
        begin
            timestamp_data       <= timestamp;
            trigger_counter_data <= trigger_counter;
        end
    end

    always_comb
    begin
        if (write_timestamp)
            payload = timestamp_data[`TLU_PAYLOAD_W-1:0];
        else if (tlu_mode == MODE_DATA)
            payload = tlu_number;
        else
            payload = trigger_counter_data[`TLU_PAYLOAD_W-1:0];
    end

    assign trigger_data = {1'b1, payload}; // bit 31 marks a trigger word

endmodule

// File: src.f
+incdir+include
logic/tlu_pkg.sv
logic/tlu_timer_if.sv
logic/tlu_handshake_fsm.sv
logic/tlu_cycle_timer.sv
logic/tlu_data_deserializer.sv
logic/trigger_record.sv
logic/tlu_controller.sv
testbench/tb_tlu_controller.sv

// File: testbench/tb_tlu_controller.sv
// testbench for the TLU controller, file-driven tests, TLU response model, checks, watchdog
`timescale 1ns/1ps
`include "tlu_defs.svh"

module tb_tlu_controller;
    import tlu_pkg::*;

    logic TRIGGER_CLK = 1'b0, RESET = 1'b1;
    logic trigger = 1'b0, trigger_flag = 1'b0, trigger_veto = 1'b0, trigger_enable = 1'b1;
    logic trigger_acknowledge = 1'b0, tlu_trigger_data_msb_first = 1'b0;
    logic tlu_enable_veto = 1'b0, tlu_reset_flag = 1'b0, write_timestamp = 1'b0;
    logic trigger_counter_set = 1'b0;
    tlu_mode_t tlu_mode = MODE_FLAG;
    logic [7:0] tlu_trigger_low_time_out = 8'd0;
    logic [4:0] tlu_clock_cycles = 5'd0;
    logic [3:0] tlu_trigger_data_delay = 4'd0;
    logic [31:0] trigger_counter_set_value = '0;
    logic trigger_data_write, fifo_preempt_req, trigger_accepted_flag, busy;
    logic tlu_clock_enable, tlu_assert_veto, low_timeout_error, accept_error;
    logic [31:0] trigger_data, timestamp_data, trigger_counter_data;

    int errors = 0, n_writes = 0, n_accepts = 0, n_preempts = 0, wd_cycles = 0;
    int n_clk_cycles = 0;
    int seed = 32'h416c217a;
    int cur_bits = 0, cur_delay = 0, cur_msb = 0;
    logic [31:0] cur_number = '0;
    logic [31:0] exp_count = '0; // trigger count expected in the next snapshot

    tlu_controller dut_i (.*);

    always #20 TRIGGER_CLK = ~TRIGGER_CLK;

    // counts pulses seen before each edge updates them
    always @(posedge TRIGGER_CLK)
    begin
        if (!RESET && trigger_data_write)
            n_writes++;
        if (!RESET && trigger_accepted_flag)
            n_accepts++;
        if (!RESET && fifo_preempt_req)
            n_preempts++;
        if (!RESET && tlu_clock_enable)
            n_clk_cycles++;
    end

    task automatic step;
        @(posedge TRIGGER_CLK);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // TLU side: start bit, then the number, one bit per divisor period
    task automatic send_number;
        int n;
        logic b;
        n = (cur_bits == 0) ? `TLU_MAX_BITS : cur_bits;
        repeat (cur_delay) step();
        for (int k = 0; k < n; k++)
        begin
            if (k == 0)
                b = 1'b1;
            else if (cur_msb != 0)
                b = cur_number[n - 1 - k];
            else
                b = cur_number[k - 1];
            trigger = b;
            repeat (`TLU_DIVISOR) step();
        end
        trigger = 1'b0;
    endtask

    initial
    begin
        forever
        begin
            step();
            if (tlu_clock_enable)
                send_number();
        end
    end

    task automatic wait_busy;
        int n;
        n = 0;
        while (!busy && n < 20)
        begin
            step();
            n++;
        end
        if (!busy)
        begin
            $display("busy never rose after the trigger");
            errors++;
        end
    endtask

    task automatic pulse_flag;
        trigger_flag = 1'b1;
        step();
        trigger_flag = 1'b0;
    endtask

    // polls for the word and compares it while the write strobe is high
    task automatic wait_write(input logic [31:0] expected);
        int n;
        n = 0;
        while (!trigger_data_write && n < 400)
        begin
            step();
            n++;
        end
        if (trigger_data_write)
            check_value("trigger_data", trigger_data, expected);
        else
        begin
            $display("no trigger word was written within 400 cycles");
            errors++;
        end
    endtask

    task automatic give_ack(input int delay);
        repeat (delay) step();
        check_value("busy", busy, 1'b1); // still waiting for the acknowledge
        trigger_acknowledge = 1'b1;
        step();
        check_value("busy", busy, 1'b0);
        trigger_acknowledge = 1'b0;
    endtask

    int fd, n_tests, t_type[32], t_mode[32], t_bits[32], t_msb[32], t_delay[32], t_ack[32];
    logic [31:0] t_num[32], t_exp[32];
    string line;

    initial
    begin
        int w0, a0, p0, c0, e0, ack, n_exp, n_clk;
        fd = $fopen("testbench/tlu_stim.txt", "r");
        n_tests = 0;
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && n_tests < 32)
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 4 && line[0] != "#")
                begin
                    void'($sscanf(line, "%h %h %h %h %h %h %h %h", t_type[n_tests],
                          t_mode[n_tests], t_bits[n_tests], t_msb[n_tests], t_delay[n_tests],
                          t_num[n_tests], t_ack[n_tests], t_exp[n_tests]));
                    wd_cycles += 120 + 4 * `TLU_MAX_BITS + t_delay[n_tests] + t_ack[n_tests];
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        wd_cycles = 2 * (wd_cycles + 20);

        repeat (8) step();
        RESET = 1'b0;
        repeat (2) step();

        for (int t = 0; t < n_tests; t++)
        begin
            w0 = n_writes;
            a0 = n_accepts;
            p0 = n_preempts;
            c0 = n_clk_cycles;
            e0 = errors;
            n_exp = (t_type[t] >= 6) ? 0 : 1;
            // TLU clock runs bit count times divisor cycles, a count of 0 means 32
            n_clk = (t_mode[t] == 3 && n_exp == 1)
                    ? `TLU_DIVISOR * ((t_bits[t] == 0) ? `TLU_MAX_BITS : t_bits[t]) : 0;
            ack = (t_ack[t] == 'hff) ? ($unsigned($random(seed)) % 8) : t_ack[t];
            tlu_mode = tlu_mode_t'(t_mode[t][1:0]);
            tlu_clock_cycles = t_bits[t][4:0];
            tlu_trigger_data_msb_first = t_msb[t][0];
            tlu_trigger_data_delay = t_delay[t][3:0];
            cur_bits = t_bits[t];
            cur_msb = t_msb[t];
            cur_delay = t_delay[t];
            cur_number = t_num[t];
            case (t_type[t])
                1:
                begin
                    trigger_counter_set_value = t_num[t];
                    trigger_counter_set = 1'b1;
                    step();
                    trigger_counter_set = 1'b0;
                    exp_count = t_num[t];
                end
                2:
                begin
                    write_timestamp = 1'b1;
                    tlu_reset_flag = 1'b1;
                    step();
                    tlu_reset_flag = 1'b0;
                    repeat (t_num[t] - 1) step(); // flag is driven K cycles after the pulse
                end
                5: tlu_trigger_low_time_out = 8'd10;
                default: ;
            endcase
            if (t_type[t] == 6)
            begin
                trigger = 1'b1; // ignored in flag mode
                repeat (2) step();
                check_value("accept_error", accept_error, 1'b1);
                trigger = 1'b0;
                repeat (2) step();
                check_value("accept_error", accept_error, 1'b0);
            end
            else if (t_type[t] == 7)
            begin
                trigger_enable = 1'b0;
                repeat (2) step();
                check_value("tlu_assert_veto", tlu_assert_veto, 1'b1);
                pulse_flag();
                repeat (10) step();
                tlu_mode = MODE_HANDSHAKE; // TLU veto only applies with the busy handshake
                trigger_enable = 1'b1;
                tlu_enable_veto = 1'b1;
                trigger_veto = 1'b1;
                repeat (2) step();
                check_value("tlu_assert_veto", tlu_assert_veto, 1'b1);
                tlu_enable_veto = 1'b0;
                trigger_veto = 1'b0;
                repeat (2) step();
                check_value("tlu_assert_veto", tlu_assert_veto, 1'b0);
            end
            else
            begin
                if (t_mode[t] >= 2)
                begin
                    trigger = 1'b1;
                    wait_busy();
                    if (t_type[t] == 5)
                    begin
                        for (int n = 0; n < 40 && !low_timeout_error; n++)
                            step();
                        check_value("low_timeout_error", low_timeout_error, 1'b1);
                    end
                    trigger = 1'b0;
                end
                else
                    pulse_flag();
                if (t_type[t] == 3)
                    pulse_flag(); // second trigger while busy
                if (t_type[t] == 4)
                begin
                    trigger_acknowledge = 1'b1; // one cycle, long before the word
                    step();
                    trigger_acknowledge = 1'b0;
                end
                wait_write(t_exp[t]);
                check_value("trigger_counter_data", trigger_counter_data, exp_count);
                if (t_type[t] == 2)
                    check_value("timestamp_data", timestamp_data, t_num[t]);
                exp_count++;
                if (t_type[t] == 4)
                begin
                    step();
                    check_value("busy", busy, 1'b0);
                end
                else
                    give_ack(ack);
                write_timestamp = 1'b0;
                tlu_trigger_low_time_out = 8'd0;
            end
            repeat (4) step();
            check_value("low_timeout_error", low_timeout_error, 1'b0);
            check_value("write count", n_writes - w0, n_exp);
            check_value("accept count", n_accepts - a0, n_exp);
            check_value("preempt count", n_preempts - p0, n_exp);
            check_value("tlu_clock_enable cycles", n_clk_cycles - c0, n_clk);
            $display("test %0d type %0d mode %0d: %s", t, t_type[t], t_mode[t],
                     (errors == e0) ? "ok" : "failed");
        end

        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge TRIGGER_CLK);
        $display("watchdog expired before all tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: testbench/tlu_stim.txt
# type mode bits msb_first delay number ack_delay expected_word, all hex, ack ff is random
# type 0 trigger, 1 counter load, 2 timestamp, 3 busy retrigger, 4 early ack, 5 timeout, 6 accept error, 7 veto
0 0 0 0 0 00000000 2 80000000
0 1 0 0 0 00000000 0 80000001
1 0 0 0 0 00001234 1 80001234
0 2 0 0 0 00000000 3 80001235
0 3 8 1 0 000000a5 2 80000025
0 3 8 0 5 0000005a 0 8000005a
0 3 f 1 5 00001abc 4 80001abc
0 3 f 0 0 00007fff 1 80003fff
0 3 0 1 0 12345678 2 92345678
0 3 0 0 5 4321abcd ff c321abcd
2 0 0 0 0 00000014 1 80000014
3 2 0 0 0 00000000 a 8000123d
4 2 0 0 0 00000000 0 8000123e
3 0 0 0 0 00000000 ff 8000123f
5 2 0 0 0 00000000 2 80001240
6 0 0 0 0 00000000 0 00000000
7 0 0 0 0 00000000 0 00000000
0 0 0 0 0 00000000 ff 80001241
